//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := mini_core_tb
FILELIST  := filelist.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Done: no errors

SRCS := $(wildcard rtl/*.sv rtl/*.svh dv/*.sv) $(FILELIST)

.PHONY: all run clean

all: run

$(BIN): $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- dv/mini_core_checker.sv
// port-level properties of mini_core, sampled on the rising clock and held off during reset
`timescale 1ns/10ps

module mini_core_checker (
  input logic CLK,
  input logic nRST,
  input logic imem_req,
  input logic out_valid,
  input logic wfi
);

  // failed assertions so far
  int fails = 0;

  // no fetch once halted
  a_no_req_in_wfi: assert property (@(posedge CLK) disable iff (!nRST) wfi |-> !imem_req)
    else begin
      fails++;
      $error("imem_req high while wfi is set");
    end

  // halt is sticky until reset
  a_wfi_sticky: assert property (@(posedge CLK) disable iff (!nRST) !$fell(wfi))
    else begin
      fails++;
      $error("wfi dropped without reset");
    end

  // strobe must always be driven
  a_valid_known: assert property (@(posedge CLK) disable iff (!nRST) !$isunknown(out_valid))
    else begin
      fails++;
      $error("out_valid unknown after reset");
    end

  // no result once halted for a cycle
  a_quiet_after_wfi: assert property (@(posedge CLK) disable iff (!nRST) wfi |=> !out_valid)
    else begin
      fails++;
      $error("out_valid seen after wfi");
    end

endmodule

bind mini_core mini_core_checker i_mini_core_checker (
  .CLK       (CLK),
  .nRST      (nRST),
  .imem_req  (imem_req),
  .out_valid (out_valid),
  .wfi       (wfi)
);

//--- dv/mini_core_tb.sv
// programs run from address zero and must end in HALT; rom is modeled here, one-cycle read latency
`timescale 1ns/10ps
`include "mini_core_settings.svh"

module mini_core_tb;

  import mini_core_pkg::*;

  localparam int ROM_WORDS  = 1 << `MC_PC_WIDTH;
  localparam int ALU_LEN    = 13;
  localparam int MUL_LEN    = 19;
  localparam int RAND_LEN   = 40;
  localparam int RAND_TESTS = 4;
  localparam int HALT_LEN   = 8;
  localparam int TO_FACTOR  = 10;
  localparam int TO_SLACK   = 50;
  // quiet cycles watched after wfi
  localparam int WATCH      = 20;
  localparam int CYCLE_LIMIT = (ALU_LEN * TO_FACTOR + TO_SLACK)
                             + (MUL_LEN * TO_FACTOR + TO_SLACK)
                             + RAND_TESTS * (RAND_LEN * TO_FACTOR + TO_SLACK)
                             + (HALT_LEN * TO_FACTOR + TO_SLACK);
  localparam logic [31:0] SEED = 32'h40a7;

  logic   CLK;
  logic   nRST;
  logic   rst_req = 1'b0;
  logic   imem_req;
  pc_t    imem_addr;
  instr_t imem_data = '0;
  logic   out_valid;
  word_t  out_data;
  logic   wfi;

  // rom and its one-deep request pipe
  instr_t rom [ROM_WORDS];
  pc_t    pend_addr;
  logic   pend_valid;

  // expected outputs from the reference model
  word_t exp_vals [ROM_WORDS];
  int    exp_len;
  int    got;

  int errors = 0;
  int tests  = 0;
  int failed = 0;
  int prog_len;
  int cycles = 0;
  logic [31:0] rng = SEED;

  tb_clock_gen i_tb_clock_gen (
    .rst_req (rst_req),
    .CLK     (CLK),
    .nRST    (nRST)
  );

  mini_core i_mini_core (
    .CLK       (CLK),
    .nRST      (nRST),
    .imem_req  (imem_req),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .out_valid (out_valid),
    .out_data  (out_data),
    .wfi       (wfi)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic instr_t enc(opcode_t op, reg_idx_t d, reg_idx_t s, logic [5:0] imm);
    return {op, d, s, imm};
  endfunction

  function automatic instr_t enc_li(reg_idx_t d, logic [8:0] imm);
    return {OP_LI, d, imm};
  endfunction

  // walks the rom in order until HALT, fills exp_vals, returns the count
  function automatic int ref_run();
    word_t       r [8];
    int          n;
    instr_t      ins;
    opcode_t     op;
    reg_idx_t    d;
    reg_idx_t    s;
    word_t       i6;
    logic [31:0] prod;
    n = 0;
    for (int i = 0; i < 8; i++) begin
      r[i] = '0;
    end
    for (int a = 0; a < ROM_WORDS; a++) begin
      ins = rom[a];
      op  = ins[15:12];
      d   = ins[11:9];
      s   = ins[8:6];
      // two's complement of a 6-bit field
      i6  = ins[5] ? word_t'(ins[5:0]) - word_t'(64) : word_t'(ins[5:0]);
      case (op)
        OP_LI:   r[d] = word_t'(ins[8:0]);
        OP_ADDI: r[d] = r[s] + i6;
        OP_ADD:  r[d] = r[d] + r[s];
        OP_SUB:  r[d] = r[d] - r[s];
        OP_XOR:  r[d] = r[d] ^ r[s];
        OP_MUL: begin
          prod = 32'(r[d]) * 32'(r[s]);
          r[d] = word_t'(prod);
        end
        OP_OUT: begin
          exp_vals[n] = r[s];
          n++;
        end
        OP_HALT: return n;
        default: ;
      endcase
    end
    return n;
  endfunction

  // unused words are no-ops tagged with their own address
  task automatic clear_rom();
    for (int a = 0; a < ROM_WORDS; a++) begin
      rom[a] = instr_t'(a);
    end
    prog_len = 0;
  endtask

  task automatic put(instr_t w);
    rom[prog_len] = w;
    prog_len++;
  endtask

  task automatic build_alu();
    clear_rom();
    put(enc_li(3'd1, 9'd300));
    put(enc(OP_OUT, 3'd0, 3'd1, 6'd0));
    // 300 - 5
    put(enc(OP_ADDI, 3'd2, 3'd1, 6'h3b));
    put(enc(OP_OUT, 3'd0, 3'd2, 6'd0));
    put(enc(OP_ADD, 3'd2, 3'd1, 6'd0));
    put(enc(OP_OUT, 3'd0, 3'd2, 6'd0));
    put(enc_li(3'd3, 9'd7));
    put(enc(OP_OUT, 3'd0, 3'd3, 6'd0));
    // 7 - 595 wraps
    put(enc(OP_SUB, 3'd3, 3'd2, 6'd0));
    put(enc(OP_OUT, 3'd0, 3'd3, 6'd0));
    put(enc(OP_XOR, 3'd3, 3'd1, 6'd0));
    put(enc(OP_OUT, 3'd0, 3'd3, 6'd0));
    put(enc(OP_HALT, 3'd0, 3'd0, 6'd0));
  endtask

  task automatic build_mul_chain();
    clear_rom();
    put(enc_li(3'd1, 9'd3));
    put(enc_li(3'd2, 9'd5));
    // powers of five overflow the word after a few steps
    for (int k = 0; k < 8; k++) begin
      put(enc(OP_MUL, 3'd1, 3'd2, 6'd0));
      put(enc(OP_OUT, 3'd0, 3'd1, 6'd0));
    end
    put(enc(OP_HALT, 3'd0, 3'd0, 6'd0));
  endtask

  task automatic build_random();
    opcode_t op;
    clear_rom();
    for (int k = 0; k < RAND_LEN - 1; k++) begin
      rng = xorshift(rng);
      op  = rng[3:0];
      // keep HALT for the last slot only
      if (op == OP_HALT) begin
        op = OP_OUT;
      end
      put({op, rng[27:16]});
    end
    put(enc(OP_HALT, 3'd0, 3'd0, 6'd0));
  endtask

  task automatic build_halt_tail();
    clear_rom();
    put(enc_li(3'd4, 9'd42));
    put(enc(OP_OUT, 3'd0, 3'd4, 6'd0));
    put(enc(OP_HALT, 3'd0, 3'd0, 6'd0));
    // none of these may run
    put(enc(OP_OUT, 3'd0, 3'd4, 6'd0));
    put(enc(OP_OUT, 3'd0, 3'd4, 6'd0));
    put(enc_li(3'd4, 9'd1));
    put(enc(OP_OUT, 3'd0, 3'd4, 6'd0));
    put(enc(OP_OUT, 3'd0, 3'd4, 6'd0));
  endtask

  task automatic check_bit(string name, logic v, logic e);
    if (v !== e) begin
      $display("[ERROR] %0t %s: got %b expected %b", $time, name, v, e);
      errors++;
    end
  endtask

  // reset, run to wfi, then watch the halted core
  task automatic run_program(string name);
    int err0;
    err0 = errors;
    rst_req <= 1'b1;
    @(negedge CLK);
    rst_req <= 1'b0;
    while (nRST) @(negedge CLK);
    exp_len = ref_run();
    got     = 0;
    while (!nRST) @(negedge CLK);
    while (!imem_req) @(negedge CLK);
    if (imem_addr !== '0) begin
      $display("[ERROR] %0t imem_addr: got %h expected %h", $time, imem_addr, pc_t'(0));
      errors++;
    end
    while (!wfi) @(negedge CLK);
    for (int k = 0; k < WATCH; k++) begin
      @(negedge CLK);
      if (out_valid) begin
        $display("out_valid seen after wfi at %0t", $time);
        errors++;
      end
      if (imem_req) begin
        $display("imem_req raised after wfi at %0t", $time);
        errors++;
      end
    end
    if (got != exp_len) begin
      $display("[ERROR] %0t out count: got %0d expected %0d", $time, got, exp_len);
      errors++;
    end
    tests++;
    if (errors != err0) begin
      failed++;
      $display("test %s: FAIL (%0d errors)", name, errors - err0);
    end else begin
      $display("test %s: pass (%0d outputs)", name, got);
    end
  endtask

  // rom answers on the falling edge after the request cycle
  always @(negedge CLK) begin
    if (!nRST) begin
      pend_valid <= 1'b0;
    end else begin
      if (pend_valid) begin
        imem_data <= rom[pend_addr];
      end
      pend_valid <= imem_req;
      pend_addr  <= imem_addr;
    end
  end

  // result comparison
  always @(negedge CLK) begin
    if (nRST && out_valid) begin
      if (got >= exp_len) begin
        $display("unexpected extra output %h at %0t", out_data, $time);
        errors++;
      end else if (out_data !== exp_vals[got]) begin
        $display("[ERROR] %0t out_data: got %h expected %h", $time, out_data, exp_vals[got]);
        errors++;
      end
      got++;
    end
  end

  // run limit
  always @(posedge CLK) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("run stopped after %0d cycles without finishing", cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    #1;
    check_bit("wfi", wfi, 1'b0);
    check_bit("out_valid", out_valid, 1'b0);
    check_bit("imem_req", imem_req, 1'b0);
    if (imem_addr !== '0) begin
      $display("[ERROR] %0t imem_addr: got %h expected %h", $time, imem_addr, pc_t'(0));
      errors++;
    end
    build_alu();
    run_program("alu_directed");
    build_mul_chain();
    run_program("mul_chain");
    for (int t = 0; t < RAND_TESTS; t++) begin
      build_random();
      run_program($sformatf("random_%0d", t));
    end
    build_halt_tail();
    run_program("halt_tail");
    // port assertions of the bound checker count as errors too
    errors += i_mini_core.i_mini_core_checker.fails;
    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- dv/tb_clock_gen.sv
// 10 ns clock from time zero; nRST low for three cycles at start and again after each rst_req
`timescale 1ns/10ps

module tb_clock_gen (
  input  logic rst_req,
  output logic CLK,
  output logic nRST
);

  // falling edges left before reset release
  int hold;

  initial begin
    CLK  = 1'b0;
    nRST = 1'b0;
    hold = 3;
  end

  always #5 CLK = ~CLK;

  // reset moves on the falling edge, away from the DUT's sampling edge
  always @(negedge CLK) begin
    if (rst_req) begin
      nRST <= 1'b0;
      hold <= 3;
    end else if (hold != 0) begin
      hold <= hold - 1;
      if (hold == 1) begin
        nRST <= 1'b1;
      end
    end
  end

endmodule

//--- filelist.f
+incdir+rtl
rtl/mini_core_pkg.sv
rtl/fetch_unit.sv
rtl/instr_queue.sv
rtl/execute_unit.sv
rtl/mini_core.sv
dv/tb_clock_gen.sv
dv/mini_core_checker.sv
dv/mini_core_tb.sv

//--- rtl/execute_unit.sv
// in-order execute with no forwarding needed; registers reset to zero and HALT is left only by reset
`timescale 1ns/10ps
`include "mini_core_settings.svh"

module execute_unit (
  input  logic                        CLK,
  input  logic                        nRST,
  input  logic                        empty,
  input  mini_core_pkg::fetch_entry_t head,
  output logic                        pop,
  output logic                        out_valid,
  output mini_core_pkg::word_t        out_data,
  output logic                        halt_instr
);

  import mini_core_pkg::*;

  localparam mul_cnt_t MUL_LAST = mul_cnt_t'(`MC_MUL_CYCLES - 1);

  exec_state_t state;

  // register file
  word_t regs [`MC_NREGS];

  // decoded fields of the head entry
  opcode_t  opcode;
  reg_idx_t rd;
  reg_idx_t rs;
  word_t    rd_val;
  word_t    rs_val;
  word_t    imm6_ext;
  word_t    imm9_ext;

  // multiplier datapath
  word_t    mul_acc;
  word_t    mul_mcand;
  word_t    mul_mplier;
  word_t    mul_pp;
  word_t    mul_sum;
  reg_idx_t mul_rd;
  mul_cnt_t mul_cnt;

  assign opcode = head.instr[15:12];
  assign rd     = head.instr[11:9];
  assign rs     = head.instr[8:6];
  assign rd_val = regs[rd];
  assign rs_val = regs[rs];

  // imm6 signed, imm9 unsigned
  assign imm6_ext = {{(`MC_XLEN-6){head.instr[5]}}, head.instr[5:0]};
  assign imm9_ext = {{(`MC_XLEN-9){1'b0}}, head.instr[8:0]};

  // take an instruction only when idle and one is there
  assign pop = (state == EXEC_RUN) && !empty;

  // one-cycle pulse, top turns it into the halt flag
  assign halt_instr = pop && (opcode == OP_HALT);

  // partial product for this step's multiplier bits
  always_comb begin
    mul_pp = '0;
    for (int i = 0; i < `MC_MUL_STEP; i++) begin
      if (mul_mplier[i]) begin
        mul_pp = mul_pp + (mul_mcand << i);
      end
    end
  end

  // only the low word is kept
  assign mul_sum = mul_acc + mul_pp;

  // state, register file and out strobe
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state     <= EXEC_RUN;
      out_valid <= 1'b0;
      mul_cnt   <= '0;
      for (int i = 0; i < `MC_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      out_valid <= pop && (opcode == OP_OUT);
      case (state)
        EXEC_RUN: begin
          if (pop) begin
            case (opcode)
              OP_LI:   regs[rd] <= imm9_ext;
              OP_ADDI: regs[rd] <= rs_val + imm6_ext;
              OP_ADD:  regs[rd] <= rd_val + rs_val;
              OP_SUB:  regs[rd] <= rd_val - rs_val;
              OP_XOR:  regs[rd] <= rd_val ^ rs_val;
              OP_MUL: begin
                state   <= EXEC_MUL;
                mul_cnt <= '0;
              end
              OP_HALT: state <= EXEC_HALTED;
              // out handled above, the rest do nothing
              default: ;
            endcase
          end
        end
        EXEC_MUL: begin
          mul_cnt <= mul_cnt + 1'b1;
          // last step, write back and resume next cycle
          if (mul_cnt == MUL_LAST) begin
            regs[mul_rd] <= mul_sum;
            state        <= EXEC_RUN;
          end
        end
        // parked until reset
        EXEC_HALTED: state <= EXEC_HALTED;
        default:     state <= EXEC_RUN;
      endcase
    end
  end

  // multiplier operands and out data
  always_ff @(posedge CLK) begin
    if (pop && (opcode == OP_MUL)) begin
      mul_acc    <= '0;
      mul_mcand  <= rd_val;
      mul_mplier <= rs_val;
      mul_rd     <= rd;
    end else if (state == EXEC_MUL) begin
      mul_acc    <= mul_sum;
      mul_mcand  <= mul_mcand << `MC_MUL_STEP;
      mul_mplier <= mul_mplier >> `MC_MUL_STEP;
    end
    if (pop && (opcode == OP_OUT)) begin
      out_data <= rs_val;
    end
  end

endmodule

//--- rtl/fetch_unit.sv
// rom must answer every request with data exactly one cycle later; no stall and no redirect
`timescale 1ns/10ps
`include "mini_core_settings.svh"

module fetch_unit (
  input  logic                        CLK,
  input  logic                        nRST,
  input  logic                        halt,
  input  logic                        space,
  output logic                        imem_req,
  output mini_core_pkg::pc_t          imem_addr,
  input  mini_core_pkg::instr_t       imem_data,
  output logic                        push,
  output mini_core_pkg::fetch_entry_t push_entry
);

  import mini_core_pkg::*;

  // next address to request
  pc_t pc;
  // address of the request in flight
  pc_t req_pc;
  // low until the first edge after reset release
  logic run;

  // request while the queue can still take the in-flight word
  // halt stops new requests, the last one in flight still lands
  assign imem_req  = run & space & ~halt;
  assign imem_addr = pc;

  // sequencing state
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc   <= '0;
      run  <= 1'b0;
      push <= 1'b0;
    end else begin
      run <= 1'b1;
      // data comes back next cycle, push it then
      push <= imem_req;
      if (imem_req) begin
        pc <= pc + 1'b1;
      end
    end
  end

  // remember which address the rom is answering
  always_ff @(posedge CLK) begin
    if (imem_req) begin
      req_pc <= pc;
    end
  end

  // pair the returned word with its address
  assign push_entry.pc    = req_pc;
  assign push_entry.instr = imem_data;

endmodule

//--- rtl/instr_queue.sv
// circular fifo, depth from MC_QDEPTH (power of two); a push into a full queue is not guarded
`timescale 1ns/10ps
`include "mini_core_settings.svh"

module instr_queue (
  input  logic                        CLK,
  input  logic                        nRST,
  input  logic                        push,
  input  mini_core_pkg::fetch_entry_t push_entry,
  input  logic                        pop,
  output mini_core_pkg::fetch_entry_t head,
  output logic                        empty,
  output logic                        space
);

  import mini_core_pkg::*;

  // storage, no reset needed
  fetch_entry_t mem [`MC_QDEPTH];

  qptr_t   wptr;
  qptr_t   rptr;
  qcount_t count;

  // pointers and fill level
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      // pointers wrap on their own width
      if (push) begin
        wptr <= wptr + 1'b1;
      end
      if (pop) begin
        rptr <= rptr + 1'b1;
      end
      // both at once leaves count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // write side
  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wptr] <= push_entry;
    end
  end

  // oldest entry always visible
  assign head  = mem[rptr];
  assign empty = (count == '0);

  // two free slots, one for the request already in flight
  assign space = (count <= qcount_t'(`MC_QDEPTH - 2));

endmodule

//--- rtl/mini_core.sv
// core top; external rom answers one cycle after imem_req, wfi holds until nRST
`timescale 1ns/10ps

module mini_core (
  input  logic                  CLK,
  input  logic                  nRST,
  output logic                  imem_req,
  output mini_core_pkg::pc_t    imem_addr,
  input  mini_core_pkg::instr_t imem_data,
  output logic                  out_valid,
  output mini_core_pkg::word_t  out_data,
  output logic                  wfi
);

  import mini_core_pkg::*;

  // fetch to queue
  logic         push;
  fetch_entry_t push_entry;
  logic         space;

  // queue to execute
  logic         pop;
  logic         empty;
  fetch_entry_t head;

  // halt path
  logic         halt_instr;
  logic         halt;

  fetch_unit i_fetch_unit (
    .CLK        (CLK),
    .nRST       (nRST),
    .halt       (halt),
    .space      (space),
    .imem_req   (imem_req),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .push       (push),
    .push_entry (push_entry)
  );

  instr_queue i_instr_queue (
    .CLK        (CLK),
    .nRST       (nRST),
    .push       (push),
    .push_entry (push_entry),
    .pop        (pop),
    .head       (head),
    .empty      (empty),
    .space      (space)
  );

  execute_unit i_execute_unit (
    .CLK        (CLK),
    .nRST       (nRST),
    .empty      (empty),
    .head       (head),
    .pop        (pop),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .halt_instr (halt_instr)
  );

  // sticky halt, only reset clears it
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      halt <= 1'b0;
    end else if (halt_instr) begin
      halt <= 1'b1;
    end
  end

  assign wfi = halt;

endmodule

//--- rtl/mini_core_pkg.sv
// shared types for the core; instruction fields are fixed at 16 bits whatever MC_XLEN says
`include "mini_core_settings.svh"

package mini_core_pkg;

  // one data word, register file and out port
  typedef logic [`MC_XLEN-1:0] word_t;

  // raw instruction word
  // [15:12] opcode, [11:9] rd, [8:6] rs, [5:0] imm6, [8:0] imm9 for li
  typedef logic [15:0] instr_t;

  typedef logic [3:0] opcode_t;

  // instruction address
  typedef logic [`MC_PC_WIDTH-1:0] pc_t;

  // register index
  typedef logic [2:0] reg_idx_t;

  // queue pointers and fill level
  typedef logic [$clog2(`MC_QDEPTH)-1:0] qptr_t;
  typedef logic [$clog2(`MC_QDEPTH+1)-1:0] qcount_t;

  // multiplier busy counter
  typedef logic [$clog2(`MC_MUL_CYCLES)-1:0] mul_cnt_t;

  // opcodes, anything not listed is a no-op
  localparam opcode_t OP_LI   = 4'd1;
  localparam opcode_t OP_ADDI = 4'd2;
  localparam opcode_t OP_ADD  = 4'd3;
  localparam opcode_t OP_SUB  = 4'd4;
  localparam opcode_t OP_XOR  = 4'd5;
  localparam opcode_t OP_MUL  = 4'd6;
  localparam opcode_t OP_OUT  = 4'd7;
  localparam opcode_t OP_HALT = 4'd15;

  // what fetch hands to the queue and the queue hands to execute
  typedef struct packed {
    pc_t    pc;
    instr_t instr;
  } fetch_entry_t;

  // execute sequencing
  typedef enum logic [1:0] {
    EXEC_RUN,
    EXEC_MUL,
    EXEC_HALTED
  } exec_state_t;

endpackage

//--- rtl/mini_core_settings.svh
// sizes for the whole core; MC_QDEPTH must be a power of two and MC_MUL_STEP must divide MC_XLEN
`ifndef MINI_CORE_SETTINGS_SVH
`define MINI_CORE_SETTINGS_SVH

// data word width, also the width of the out port
`define MC_XLEN 16

// architectural registers, r0 is an ordinary register
`define MC_NREGS 8

// instruction address width, so the rom holds 2**8 words
`define MC_PC_WIDTH 8

// instruction queue entries
`define MC_QDEPTH 4

// multiplier bits retired per busy cycle
`define MC_MUL_STEP 2

// busy cycles of one multiply
`define MC_MUL_CYCLES (`MC_XLEN / `MC_MUL_STEP)

`endif
